// File: filelist.f
common/fetch_pkg.sv
common/icache_mem_if.sv
common/fetch_bundle_if.sv
icache/icache_mem.sv
icache/icache_ctrl.sv
hdl/fetch_unit.sv
hdl/fetch_buffer.sv
hdl/fetch_top.sv
bench/mem_model.sv
bench/fetch_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the fetch front-end testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --top-module fetch_tb -f filelist.f --Mdir "$build_dir"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$build_dir/Vfetch_tb" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "PASS: all tests" "$log_file"; then
  exit 0
fi
echo "pass line not found in $log_file"
exit 1

// File: bench/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;

  localparam int          clk_period      = 10;
  localparam int          mem_latency     = 4;
  localparam logic [31:0] lcg_seed        = 32'hd868_07f7;
  localparam int          log_depth       = 1024;
  localparam int          stall_limit     = 400;
  localparam int          test_len        = 40 + 26 + 20 + 24 + 50 + 20 + 60;
  localparam int          watchdog_cycles = test_len * 40;

  logic                clock;
  logic                rst_n;
  logic [3:0]          mem2proc_response;
  logic [3:0]          mem2proc_tag;
  logic [63:0]         mem2proc_data;
  fetch_pkg::bus_cmd_t proc2mem_command;
  logic [63:0]         proc2mem_addr;
  logic [63:0]         proc2mem_data;
  fetch_pkg::bus_cmd_t dmem_command;
  logic [63:0]         dmem_addr;
  logic [63:0]         dmem_data;
  logic [3:0]          dmem_response;
  logic                dispatch_en;
  logic                redirect_en;
  logic [63:0]         redirect_pc;
  logic                inst_valid;
  logic [63:0]         inst_pc;
  logic [31:0]         inst_ir;
  logic                refuse_en;
  int                  value_errors;
  int                  other_errors;

  fetch_top fetch_top_i (
    .clock (clock), .rst_n (rst_n),
    .mem2proc_response (mem2proc_response), .mem2proc_data (mem2proc_data),
    .mem2proc_tag (mem2proc_tag), .proc2mem_command (proc2mem_command),
    .proc2mem_addr (proc2mem_addr), .proc2mem_data (proc2mem_data),
    .dmem_command (dmem_command), .dmem_addr (dmem_addr), .dmem_data (dmem_data),
    .dmem_response (dmem_response), .dispatch_en (dispatch_en),
    .redirect_en (redirect_en), .redirect_pc (redirect_pc),
    .inst_valid (inst_valid), .inst_pc (inst_pc), .inst_ir (inst_ir)
  );

  mem_model #(
    .latency (mem_latency), .seed (lcg_seed), .log_depth (log_depth)
  ) mem_model_i (
    .clock (clock), .rst_n (rst_n), .refuse_en (refuse_en),
    .command (proc2mem_command), .addr (proc2mem_addr), .data (proc2mem_data),
    .response (mem2proc_response), .tag (mem2proc_tag), .rdata (mem2proc_data)
  );

  initial begin
    clock = 1'b0;
    forever #(clk_period / 2) clock = ~clock;
  end

  task automatic check_inst(input fetch_pkg::fetch_slot_t got, input logic [63:0] exp_pc);
    fetch_pkg::fetch_slot_t exp;
    exp.pc = exp_pc;
    exp.ir = ~exp_pc[31:0];  // Content rule
    if (got.pc !== exp.pc) begin
      value_errors++;
      $display("error at %0t: inst_pc got %h expected %h", $time, got.pc, exp.pc);
    end
    if (got.ir !== exp.ir) begin
      value_errors++;
      $display("error at %0t: inst_ir got %h expected %h", $time, got.ir, exp.ir);
    end
  endtask

  task automatic check_cmd(input string name, input fetch_pkg::bus_cmd_t got,
                           input fetch_pkg::bus_cmd_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("error at %0t: %s got %s expected %s", $time, name, got.name(), exp.name());
    end
  endtask

  task automatic check_word(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      value_errors++;
      $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_resp(input string name, input logic [3:0] got, input logic [3:0] exp);
    if (got !== exp) begin
      value_errors++;
      $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      value_errors++;
      $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic apply_reset();
    repeat (3) @(posedge clock);
    @(negedge clock);
    check_flag("inst_valid", inst_valid, 1'b0);
    check_cmd("proc2mem_command", proc2mem_command, fetch_pkg::bus_none);
    rst_n = 1'b1;
  endtask

  task automatic redirect_to(input logic [63:0] pc);
    @(negedge clock);
    redirect_en = 1'b1;
    redirect_pc = pc;
    @(negedge clock);
    redirect_en = 1'b0;
  endtask

  task automatic wait_valid();
    int idle;
    idle = 0;
    while (!inst_valid && idle < stall_limit) begin
      @(negedge clock);
      idle++;
    end
    if (!inst_valid) begin
      other_errors++;
      $display("no instruction became valid within %0d cycles", stall_limit);
    end
  endtask

  // Pops n instructions and checks each one against a running pc
  task automatic dispatch_stream(input logic [63:0] start_pc, input int n);
    fetch_pkg::fetch_slot_t slot;
    logic [63:0] exp_pc;
    int got;
    int idle;
    exp_pc = start_pc;
    got = 0;
    idle = 0;
    while (got < n && idle < stall_limit) begin
      @(negedge clock);
      if (inst_valid) begin
        slot.pc = inst_pc;
        slot.ir = inst_ir;
        check_inst(slot, exp_pc);
        dispatch_en = 1'b1;
        exp_pc = exp_pc + 64'd4;
        got++;
        idle = 0;
      end else begin
        dispatch_en = 1'b0;
        idle++;
      end
    end
    @(negedge clock);
    dispatch_en = 1'b0;
    if (got < n) begin
      other_errors++;
      $display("fetch stalled after %0d of %0d instructions from %h", got, n, start_pc);
    end
  endtask

  task automatic sequential_fetch();
    dispatch_stream(64'h0, 40);
  endtask

  task automatic cache_reuse();
    int first_log;
    first_log = mem_model_i.log_count;
    redirect_to(64'h0);
    dispatch_stream(64'h0, 20);
    for (int i = first_log; i < mem_model_i.log_count && i < log_depth; i++) begin
      if (mem_model_i.log_cmd[i] == fetch_pkg::bus_load && mem_model_i.log_addr[i] < 64'h50) begin
        other_errors++;
        $display("load to %h was issued although that line was cached", mem_model_i.log_addr[i]);
      end
    end
  endtask

  task automatic redirect_mid_stream();
    dispatch_stream(64'h50, 6);
    redirect_to(64'h104);
    dispatch_stream(64'h104, 20);
  endtask

  task automatic data_priority();
    logic [63:0] st_addr;
    logic [63:0] st_data;
    int first_log;
    int stores;
    st_addr = 64'h8000;
    st_data = 64'h0123_4567_89ab_cdef;
    stores = 0;
    first_log = mem_model_i.log_count;
    redirect_to(64'h400);  // Line not cached yet
    dmem_command = fetch_pkg::bus_store;
    dmem_addr = st_addr;
    dmem_data = st_data;
    repeat (6) begin
      @(negedge clock);
      check_cmd("proc2mem_command", proc2mem_command, fetch_pkg::bus_store);
      check_word("proc2mem_addr", proc2mem_addr, st_addr);
      check_word("proc2mem_data", proc2mem_data, st_data);
      check_resp("dmem_response", dmem_response, mem2proc_response);
    end
    dmem_command = fetch_pkg::bus_none;
    dmem_addr = 64'h0;
    dmem_data = 64'h0;
    dispatch_stream(64'h400, 24);
    for (int i = first_log; i < mem_model_i.log_count && i < log_depth; i++) begin
      if (mem_model_i.log_cmd[i] == fetch_pkg::bus_store && mem_model_i.log_addr[i] == st_addr &&
          mem_model_i.log_data[i] == st_data) begin
        stores++;
      end
    end
    if (stores == 0) begin
      other_errors++;
      $display("memory never accepted the data-side store");
    end
  endtask

  task automatic back_pressure();
    fetch_pkg::fetch_slot_t slot;
    wait_valid();
    repeat (50) begin
      @(negedge clock);
      check_flag("inst_valid", inst_valid, 1'b1);
      slot.pc = inst_pc;
      slot.ir = inst_ir;
      check_inst(slot, 64'h460);  // Head must not move
    end
    dispatch_stream(64'h460, 20);
  endtask

  task automatic refusals();
    refuse_en = 1'b1;
    dispatch_stream(64'h4b0, 60);
    refuse_en = 1'b0;
    if (mem_model_i.refuse_count == 0) begin
      other_errors++;
      $display("memory model refused no command while refusal was on");
    end
  endtask

  initial begin
    rst_n = 1'b0;
    dmem_command = fetch_pkg::bus_none;
    dmem_addr = 64'h0;
    dmem_data = 64'h0;
    dispatch_en = 1'b0;
    redirect_en = 1'b0;
    redirect_pc = 64'h0;
    refuse_en = 1'b0;
    value_errors = 0;
    other_errors = 0;
    apply_reset();
    sequential_fetch();
    cache_reuse();  // Before the redirect to 0x104 evicts these lines
    redirect_mid_stream();
    data_priority();
    back_pressure();
    refusals();
    $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clock);
    $display("timeout: tests still running after %0d cycles", watchdog_cycles);
    $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module mem_model #(
  parameter int          latency   = 4,
  parameter logic [31:0] seed      = 32'h1,
  parameter int          log_depth = 1024
) (
  input  wire logic                            clock,
  input  wire logic                            rst_n,
  input  wire logic                            refuse_en,
  input  wire fetch_pkg::bus_cmd_t             command,
  input  wire logic [fetch_pkg::addr_w-1:0]    addr,
  input  wire logic [fetch_pkg::addr_w-1:0]    data,
  output logic      [fetch_pkg::mem_tag_w-1:0] response,
  output logic      [fetch_pkg::mem_tag_w-1:0] tag,
  output logic      [fetch_pkg::addr_w-1:0]    rdata
);

  logic [31:0]                    lcg_state  = seed;
  logic                           refuse_now = 1'b0;
  logic [fetch_pkg::mem_tag_w-1:0] next_tag  = 4'd1;
  logic [fetch_pkg::mem_tag_w-1:0] pend_tag [$];
  logic [fetch_pkg::addr_w-1:0]    pend_addr [$];
  int                              pend_due [$];
  int                              cycle;

  // Every accepted command, in order
  fetch_pkg::bus_cmd_t          log_cmd [log_depth];
  logic [fetch_pkg::addr_w-1:0] log_addr [log_depth];
  logic [fetch_pkg::addr_w-1:0] log_data [log_depth];
  int                           log_count;
  int                           refuse_count;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Instruction at byte address a is the inverse of a[31:0]
  function automatic logic [63:0] word_at(input logic [63:0] a);
    logic [31:0] lo;
    lo = {a[31:3], 3'b000};
    return {~(lo + 32'd4), ~lo};
  endfunction

  assign response = (command != fetch_pkg::bus_none && !refuse_now) ? next_tag : 4'd0;

  always @(posedge clock) begin
    if (!rst_n) begin
      lcg_state  <= seed;
      refuse_now <= 1'b0;
      next_tag   <= 4'd1;
      tag        <= 4'd0;
      rdata      <= 64'd0;
      pend_tag.delete();
      pend_addr.delete();
      pend_due.delete();
      cycle        = 0;
      log_count    = 0;
      refuse_count = 0;
    end else begin
      cycle = cycle + 1;
      lcg_state  <= lcg_next(lcg_state);
      refuse_now <= refuse_en && (lcg_state[31:30] == 2'b00);  // About one in four
      if (command != fetch_pkg::bus_none && refuse_now) begin
        refuse_count = refuse_count + 1;
      end
      if (response != 4'd0) begin
        if (log_count < log_depth) begin
          log_cmd[log_count]  = command;
          log_addr[log_count] = addr;
          log_data[log_count] = data;
        end
        log_count = log_count + 1;
        next_tag <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
        if (command == fetch_pkg::bus_load) begin
          pend_tag.push_back(response);
          pend_addr.push_back(addr);
          pend_due.push_back(cycle + latency);
        end
      end
      if (pend_due.size() > 0 && pend_due[0] <= cycle) begin
        tag   <= pend_tag.pop_front();
        rdata <= word_at(pend_addr.pop_front());
        void'(pend_due.pop_front());
      end else begin
        tag   <= 4'd0;
        rdata <= 64'd0;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top #(
  parameter int                           fb_depth = 8,
  parameter logic [fetch_pkg::addr_w-1:0] reset_pc = '0
) (
  input  wire logic                              clock,
  input  wire logic                              rst_n,
  input  wire logic [fetch_pkg::mem_tag_w-1:0]   mem2proc_response,
  input  wire logic [fetch_pkg::addr_w-1:0]      mem2proc_data,
  input  wire logic [fetch_pkg::mem_tag_w-1:0]   mem2proc_tag,
  output fetch_pkg::bus_cmd_t                    proc2mem_command,
  output logic      [fetch_pkg::addr_w-1:0]      proc2mem_addr,
  output logic      [fetch_pkg::addr_w-1:0]      proc2mem_data,
  input  wire fetch_pkg::bus_cmd_t               dmem_command,
  input  wire logic [fetch_pkg::addr_w-1:0]      dmem_addr,
  input  wire logic [fetch_pkg::addr_w-1:0]      dmem_data,
  output logic      [fetch_pkg::mem_tag_w-1:0]   dmem_response,
  input  wire logic                              dispatch_en,
  input  wire logic                              redirect_en,
  input  wire logic [fetch_pkg::addr_w-1:0]      redirect_pc,
  output logic                                   inst_valid,
  output logic      [fetch_pkg::addr_w-1:0]      inst_pc,
  output logic      [fetch_pkg::inst_w-1:0]      inst_ir
);

  logic                            dmem_active;
  fetch_pkg::bus_cmd_t             imem_command;
  logic [fetch_pkg::addr_w-1:0]    imem_addr;
  logic [fetch_pkg::mem_tag_w-1:0] imem_response;
  logic [fetch_pkg::addr_w-1:0]    fetch_addr;
  logic [fetch_pkg::addr_w-1:0]    fetch_data;
  logic                            fetch_valid;

  icache_mem_if   cache_if ();
  fetch_bundle_if bundle_if ();

  // Data side owns the bus whenever it asks
  assign dmem_active      = (dmem_command != fetch_pkg::bus_none);
  assign proc2mem_command = dmem_active ? dmem_command : imem_command;
  assign proc2mem_addr    = dmem_active ? dmem_addr : imem_addr;
  assign proc2mem_data    = dmem_active ? dmem_data : '0;  // I-side never stores
  assign dmem_response    = dmem_active ? mem2proc_response : '0;
  assign imem_response    = dmem_active ? '0 : mem2proc_response;

  icache_ctrl icache_ctrl_i (
    .clock         (clock),
    .rst_n         (rst_n),
    .fetch_addr    (fetch_addr),
    .fetch_data    (fetch_data),
    .fetch_valid   (fetch_valid),
    .imem_command  (imem_command),
    .imem_addr     (imem_addr),
    .imem_response (imem_response),
    .mem_tag       (mem2proc_tag),
    .mem_data      (mem2proc_data),
    .cache         (cache_if.master)
  );

  icache_mem icache_mem_i (
    .clock (clock),
    .rst_n (rst_n),
    .port  (cache_if.slave)
  );

  fetch_unit #(
    .reset_pc (reset_pc)
  ) fetch_unit_i (
    .clock       (clock),
    .rst_n       (rst_n),
    .redirect_en (redirect_en),
    .redirect_pc (redirect_pc),
    .fetch_addr  (fetch_addr),
    .fetch_data  (fetch_data),
    .fetch_valid (fetch_valid),
    .bundle      (bundle_if.source)
  );

  fetch_buffer #(
    .fb_depth (fb_depth)
  ) fetch_buffer_i (
    .clock       (clock),
    .rst_n       (rst_n),
    .bundle      (bundle_if.sink),
    .redirect_en (redirect_en),
    .dispatch_en (dispatch_en),
    .inst_valid  (inst_valid),
    .inst_pc     (inst_pc),
    .inst_ir     (inst_ir)
  );

endmodule

`default_nettype wire

// File: hdl/fetch_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_buffer #(
  parameter int fb_depth = 8
) (
  input  wire logic                          clock,
  input  wire logic                          rst_n,
  fetch_bundle_if.sink                       bundle,
  input  wire logic                          redirect_en,
  input  wire logic                          dispatch_en,
  output logic                               inst_valid,
  output logic      [fetch_pkg::addr_w-1:0]  inst_pc,
  output logic      [fetch_pkg::inst_w-1:0]  inst_ir
);

  localparam int ptr_w = (fb_depth > 1) ? $clog2(fb_depth) : 1;
  localparam int cnt_w = $clog2(fb_depth + 1);

  fetch_pkg::fetch_slot_t entries [fb_depth];

  logic [ptr_w-1:0] head;
  logic [ptr_w-1:0] tail;
  logic [ptr_w-1:0] tail_inc;
  logic [cnt_w-1:0] count;
  logic [cnt_w-1:0] n_push;
  logic             pop;

  // Wraps for depths that are not a power of two
  function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
    logic [ptr_w-1:0] nxt;
    nxt = (p == ptr_w'(fb_depth - 1)) ? '0 : p + 1'b1;
    return nxt;
  endfunction

  assign tail_inc = ptr_inc(tail);
  assign n_push   = cnt_w'(bundle.push_valid[0]) + cnt_w'(bundle.push_valid[1]);
  assign pop      = dispatch_en && inst_valid;

  assign bundle.space_ok = (count <= cnt_w'(fb_depth - 2));

  assign inst_valid = (count != '0);
  assign inst_pc    = entries[head].pc;
  assign inst_ir    = entries[head].ir;

  // Compact one or two slots, oldest first
  always_ff @(posedge clock) begin
    if (bundle.push_valid[0]) begin
      entries[tail] <= bundle.slots[0];
      if (bundle.push_valid[1]) begin
        entries[tail_inc] <= bundle.slots[1];
      end
    end else if (bundle.push_valid[1]) begin
      entries[tail] <= bundle.slots[1];
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else if (redirect_en) begin  // Flush, pop ignored
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (pop) begin
        head <= ptr_inc(head);
      end
      if (n_push == cnt_w'(2)) begin
        tail <= ptr_inc(tail_inc);
      end else if (n_push == cnt_w'(1)) begin
        tail <= tail_inc;
      end
      count <= count + n_push - cnt_w'(pop);
    end
  end

endmodule

`default_nettype wire

// File: hdl/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
  parameter logic [fetch_pkg::addr_w-1:0] reset_pc = '0
) (
  input  wire logic                          clock,
  input  wire logic                          rst_n,
  input  wire logic                          redirect_en,
  input  wire logic [fetch_pkg::addr_w-1:0]  redirect_pc,
  output logic      [fetch_pkg::addr_w-1:0]  fetch_addr,
  input  wire logic [fetch_pkg::addr_w-1:0]  fetch_data,
  input  wire logic                          fetch_valid,
  fetch_bundle_if.source                     bundle
);

  localparam int inst_w = fetch_pkg::inst_w;

  logic [fetch_pkg::addr_w-1:0] pc;
  logic [fetch_pkg::addr_w-1:0] word_addr;
  logic                         take;

  assign fetch_addr = pc;
  assign word_addr  = {pc[fetch_pkg::addr_w-1:3], 3'b000};

  // Redirect wins over any push this cycle
  assign take = fetch_valid && bundle.space_ok && !redirect_en;

  always_comb begin
    bundle.push_valid = 2'b00;
    if (take) begin
      bundle.push_valid = {1'b1, ~pc[2]};  // Low half skipped on odd slot
    end
  end

  always_comb begin
    bundle.slots[0].pc = word_addr;
    bundle.slots[0].ir = fetch_data[inst_w-1:0];
    bundle.slots[1].pc = word_addr + 'd4;
    bundle.slots[1].ir = fetch_data[2*inst_w-1:inst_w];
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      pc <= reset_pc;
    end else if (redirect_en) begin
      pc <= redirect_pc;
    end else if (take) begin
      pc <= word_addr + 'd8;  // Next aligned word
    end
  end

endmodule

`default_nettype wire

// File: icache/icache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl (
  input  wire logic                              clock,
  input  wire logic                              rst_n,
  input  wire logic [fetch_pkg::addr_w-1:0]      fetch_addr,
  output logic      [fetch_pkg::addr_w-1:0]      fetch_data,
  output logic                                   fetch_valid,
  output fetch_pkg::bus_cmd_t                    imem_command,
  output logic      [fetch_pkg::addr_w-1:0]      imem_addr,
  input  wire logic [fetch_pkg::mem_tag_w-1:0]   imem_response,
  input  wire logic [fetch_pkg::mem_tag_w-1:0]   mem_tag,
  input  wire logic [fetch_pkg::addr_w-1:0]      mem_data,
  icache_mem_if.master                           cache
);

  localparam int idx_lsb = 3;
  localparam int tag_lsb = idx_lsb + fetch_pkg::icache_idx_w;

  logic                               req_active;   // Load offered to the bus
  logic [fetch_pkg::addr_w-1:0]       req_addr;
  logic                               miss_pending; // Accepted, waiting for data
  logic [fetch_pkg::mem_tag_w-1:0]    pend_tag;
  logic [fetch_pkg::icache_idx_w-1:0] pend_idx;
  logic [fetch_pkg::icache_tag_w-1:0] pend_ctag;
  logic                               start_req;
  logic                               accepted;
  logic                               fill_hit;

  assign cache.rd_idx = fetch_addr[idx_lsb +: fetch_pkg::icache_idx_w];
  assign cache.rd_tag = fetch_addr[tag_lsb +: fetch_pkg::icache_tag_w];

  // Zero-cycle hit path
  assign fetch_valid = cache.rd_hit;
  assign fetch_data  = cache.rd_data;

  // One miss at a time, new one only once the last fill is done
  assign start_req = !fetch_valid && !req_active && !miss_pending;
  assign accepted  = req_active && (imem_response != '0);
  assign fill_hit  = miss_pending && (mem_tag == pend_tag);

  assign imem_command = req_active ? fetch_pkg::bus_load : fetch_pkg::bus_none;
  assign imem_addr    = req_addr;

  assign cache.wr_en   = fill_hit;
  assign cache.wr_idx  = pend_idx;
  assign cache.wr_tag  = pend_ctag;
  assign cache.wr_data = mem_data;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      req_active   <= 1'b0;
      miss_pending <= 1'b0;
    end else begin
      if (accepted) begin
        req_active   <= 1'b0;
        miss_pending <= 1'b1;
      end else if (start_req) begin
        req_active <= 1'b1;
      end
      if (fill_hit) begin
        miss_pending <= 1'b0;
      end
    end
  end

  // Address stays put while the bus refuses
  always_ff @(posedge clock) begin
    if (start_req) begin
      req_addr <= {fetch_addr[fetch_pkg::addr_w-1:idx_lsb], 3'b000};
    end
    if (accepted) begin
      pend_tag  <= imem_response;
      pend_idx  <= req_addr[idx_lsb +: fetch_pkg::icache_idx_w];
      pend_ctag <= req_addr[tag_lsb +: fetch_pkg::icache_tag_w];
    end
  end

endmodule

`default_nettype wire

// File: icache/icache_mem.sv
`timescale 1ns/1ps
`default_nettype none

module icache_mem (
  input  wire logic     clock,
  input  wire logic     rst_n,
  icache_mem_if.slave   port
);

  localparam int n_lines = 1 << fetch_pkg::icache_idx_w;

  logic [fetch_pkg::addr_w-1:0]       data_mem [n_lines];
  logic [fetch_pkg::icache_tag_w-1:0] tag_mem  [n_lines];
  logic [n_lines-1:0]                 line_valid;

  // Lookup is purely combinational
  assign port.rd_data = data_mem[port.rd_idx];
  assign port.rd_hit  = line_valid[port.rd_idx] &&
                        (tag_mem[port.rd_idx] == port.rd_tag);

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      line_valid <= '0;
    end else if (port.wr_en) begin
      line_valid[port.wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (port.wr_en) begin
      data_mem[port.wr_idx] <= port.wr_data;
      tag_mem[port.wr_idx]  <= port.wr_tag;
    end
  end

endmodule

`default_nettype wire

// File: common/fetch_bundle_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fetch_bundle_if;

  // Bit 0 goes with slots[0], the older instruction
  logic [1:0]                    push_valid;
  fetch_pkg::fetch_slot_t [1:0]  slots;

  // At least two entries free
  logic                          space_ok;

  modport source (
    output push_valid, slots,
    input  space_ok
  );

  modport sink (
    input  push_valid, slots,
    output space_ok
  );

endinterface

`default_nettype wire

// File: common/icache_mem_if.sv
`timescale 1ns/1ps
`default_nettype none

interface icache_mem_if;

  // Lookup side
  logic [fetch_pkg::icache_idx_w-1:0] rd_idx;
  logic [fetch_pkg::icache_tag_w-1:0] rd_tag;
  logic [fetch_pkg::addr_w-1:0]       rd_data;
  logic                               rd_hit;

  // Line fill from memory
  logic                               wr_en;
  logic [fetch_pkg::icache_idx_w-1:0] wr_idx;
  logic [fetch_pkg::icache_tag_w-1:0] wr_tag;
  logic [fetch_pkg::addr_w-1:0]       wr_data;

  modport master (
    output rd_idx, rd_tag, wr_en, wr_idx, wr_tag, wr_data,
    input  rd_data, rd_hit
  );

  modport slave (
    input  rd_idx, rd_tag, wr_en, wr_idx, wr_tag, wr_data,
    output rd_data, rd_hit
  );

endinterface

`default_nettype wire

// File: common/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  // One memory word, also the address width
  parameter int addr_w = 64;
  parameter int inst_w = 32;

  // Tag zero means no transaction
  parameter int mem_tag_w = 4;

  // Direct-mapped, one word per line
  parameter int icache_idx_w = 5;  // Address bits 7:3
  parameter int icache_tag_w = 8;  // Address bits 15:8

  typedef enum logic [1:0] {
    bus_none  = 2'h0,
    bus_load  = 2'h1,
    bus_store = 2'h2
  } bus_cmd_t;

  typedef struct packed {
    logic [addr_w-1:0] pc;
    logic [inst_w-1:0] ir;
  } fetch_slot_t;

endpackage

`default_nettype wire
